// File: src/tilesScreenPkg.sv
package tilesScreenPkg;

	// Frame buffer size
	localparam int screenWidth = 160;
	localparam int screenHeight = 120;

	// Lane layout, four lanes separated by green strips
	localparam int laneWidth = 35;
	localparam int borderWidth = 4;
	localparam int laneCount = 4;
	localparam int tileHeight = screenHeight / 6;

	typedef logic [7:0] xT;
	typedef logic [6:0] yT;
	typedef logic [2:0] colorT;

	localparam colorT colorTile = 3'b000;
	localparam colorT colorBackground = 3'b111;
	localparam colorT colorBoundary = 3'b100;
	localparam colorT colorBorder = 3'b010;
	localparam colorT colorGameOver = 3'b001;

	typedef struct packed {
		xT x;
		yT y;
		colorT color;
	} pixelT;

	// One horizontal run of laneWidth pixels
	typedef struct packed {
		xT startX;
		yT row;
		colorT color;
	} spanT;

	// Left edge of a lane: 4, 43, 82, 121
	function automatic xT laneStartX(input logic [1:0] lane);
		return xT'(borderWidth + int'(lane) * (laneWidth + borderWidth));
	endfunction

endpackage

// File: src/tilesGamePkg.sv
package tilesGamePkg;

	typedef enum logic [1:0] {
		phaseBackground = 2'd0,
		phasePlay = 2'd1,
		phaseOverSweep = 2'd2,
		phaseIdle = 2'd3
	} phaseT;

	// One falling tile, top is the screen row of its upper edge
	typedef struct packed {
		logic active;
		logic scored;
		logic [1:0] lane;
		tilesScreenPkg::yT top;
	} tileT;

	typedef logic [7:0] scoreT;

	// First row of the judge zone
	localparam int judgeTop = tilesScreenPkg::screenHeight - tilesScreenPkg::tileHeight;

endpackage

// File: src/tileField.sv
`timescale 1ns/1ps

module tileField
	import tilesScreenPkg::*, tilesGamePkg::*;
#(
	parameter int tickCycles = 416666,
	parameter int spawnCycles = 50000000,
	parameter logic [23:0] lfsrSeed = 24'h800001,
	parameter int tileSlots = 4
)
(
	input logic CLOCK_50,
	input logic arstN,
	input logic [3:0] KEY,
	input logic spanBusy,
	input logic sweepDone,
	output logic sweepStart,
	output logic sweepOver,
	output logic spanStart,
	output spanT span,
	output scoreT score
);
	localparam int tickBits = $clog2(tickCycles + 1);
	localparam int spawnBits = $clog2(spawnCycles + 1);
	localparam int slotBits = $clog2(tileSlots);
	localparam logic [tickBits-1:0] tickLast = tickBits'(tickCycles - 1);
	localparam logic [spawnBits-1:0] spawnLast = spawnBits'(spawnCycles - 1);

	logic [3:0] keySync;
	logic [3:0] keyPrev;
	logic [3:0] keyFall;
	logic [laneCount-1:0] lanePress;
	logic [23:0] lfsr;
	phaseT phase;
	logic sweepIssued;
	tileT tiles [tileSlots];
	yT bodyRows [tileSlots];
	yT drawAt [tileSlots];
	yT eraseAt [tileSlots];
	logic [tileSlots-1:0] pendDraw;
	logic [tileSlots-1:0] pendErase;
	logic [tickBits-1:0] tickCount;
	logic [spawnBits-1:0] spawnCount;
	logic [tileSlots-1:0] hitMask;
	scoreT hitCount;
	logic laneHit;
	logic missPress;
	logic fallMiss;
	logic workIdle;
	logic tickGo;
	logic spawnDue;
	logic spawnGo;
	logic issueGo;
	logic issueErase;
	logic freeFound;
	logic [slotBits-1:0] freeSlot;
	logic [slotBits-1:0] issueSlot;

	// KEY[3] is the leftmost lane
	assign keyFall = keyPrev & ~keySync;
	always_comb
	begin
		for (int l = 0; l < laneCount; l++)
			lanePress[l] = keyFall[laneCount - 1 - l];
	end

	assign workIdle = !spanBusy && !spanStart && pendDraw == '0 && pendErase == '0;
	assign tickGo = phase == phasePlay && tickCount == tickLast && workIdle;
	assign spawnDue = phase == phasePlay && spawnCount == spawnLast && workIdle && !tickGo;
	assign spawnGo = spawnDue && freeFound;
	assign issueGo = phase == phasePlay && !spanBusy && !spanStart && (pendDraw | pendErase) != '0;

	always_comb
	begin
		hitMask = '0;
		hitCount = '0;
		missPress = 1'b0;
		laneHit = 1'b0;
		for (int l = 0; l < laneCount; l++)
		begin
			laneHit = 1'b0;
			for (int s = 0; s < tileSlots; s++)
			begin
				// Bottom row top + tileHeight - 1 inside the judge zone
				if (lanePress[l] && !laneHit && tiles[s].active && !tiles[s].scored &&
					tiles[s].lane == 2'(l) && int'(tiles[s].top) >= judgeTop - tileHeight + 1)
				begin
					laneHit = 1'b1;
					hitMask[s] = 1'b1;
				end
			end
			if (lanePress[l] && laneHit)
				hitCount = hitCount + 1'b1;
			if (lanePress[l] && !laneHit)
				missPress = 1'b1;
		end

		fallMiss = 1'b0;
		freeFound = 1'b0;
		freeSlot = '0;
		issueSlot = '0;
		issueErase = 1'b0;
		// Descending scans so the lowest slot wins
		for (int s = tileSlots - 1; s >= 0; s--)
		begin
			if (tickGo && tiles[s].active && int'(tiles[s].top) == screenHeight - 1 &&
				!tiles[s].scored && !hitMask[s])
				fallMiss = 1'b1;
			if (!tiles[s].active)
			begin
				freeFound = 1'b1;
				freeSlot = slotBits'(s);
			end
			if (pendDraw[s] || pendErase[s])
			begin
				issueSlot = slotBits'(s);
				issueErase = pendErase[s];
			end
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			keySync <= '1;
			keyPrev <= '1;
			lfsr <= lfsrSeed;
			phase <= phaseBackground;
			sweepIssued <= 1'b0;
			sweepStart <= 1'b0;
			sweepOver <= 1'b0;
			spanStart <= 1'b0;
			pendDraw <= '0;
			pendErase <= '0;
			tickCount <= '0;
			spawnCount <= '0;
			score <= '0;
			for (int s = 0; s < tileSlots; s++)
			begin
				tiles[s] <= '0;
				bodyRows[s] <= '0;
			end
		end
		else
		begin
			keySync <= KEY;
			keyPrev <= keySync;
			lfsr <= {lfsr[22:0], lfsr[23] ^ lfsr[22] ^ lfsr[21] ^ lfsr[16]};
			sweepStart <= 1'b0;
			spanStart <= 1'b0;
			case (phase)
				phaseBackground, phaseOverSweep:
				begin
					// Sweep waits for the last span to drain
					if (!sweepIssued && !spanBusy && !spanStart)
					begin
						sweepStart <= 1'b1;
						sweepIssued <= 1'b1;
					end
					if (phase == phaseBackground && !sweepIssued)
					begin
						score <= '0;
						tickCount <= '0;
						spawnCount <= '0;
						for (int s = 0; s < tileSlots; s++)
						begin
							tiles[s] <= '0;
							bodyRows[s] <= '0;
						end
					end
					if (sweepDone)
					begin
						sweepIssued <= 1'b0;
						phase <= (phase == phaseBackground) ? phasePlay : phaseIdle;
					end
				end
				phasePlay:
				begin
					if (tickCount != tickLast)
						tickCount <= tickCount + 1'b1;
					else if (tickGo)
						tickCount <= '0;
					if (spawnCount != spawnLast)
						spawnCount <= spawnCount + 1'b1;
					else if (spawnDue)
						spawnCount <= '0;

					score <= score + hitCount;
					for (int s = 0; s < tileSlots; s++)
					begin
						if (hitMask[s])
							tiles[s].scored <= 1'b1;
						if (tickGo && tiles[s].active)
						begin
							pendDraw[s] <= bodyRows[s] < yT'(tileHeight) ||
								int'(tiles[s].top) < screenHeight - tileHeight;
							if (bodyRows[s] < yT'(tileHeight))
								bodyRows[s] <= bodyRows[s] + 1'b1;
							else
							begin
								// Fully on screen, so the old top row is erased
								tiles[s].top <= tiles[s].top + 1'b1;
								pendErase[s] <= 1'b1;
								if (int'(tiles[s].top) == screenHeight - 1)
									tiles[s].active <= 1'b0;
							end
						end
					end

					if (spawnGo)
					begin
						tiles[freeSlot] <= '{active: 1'b1, scored: 1'b0, lane: lfsr[1:0], top: '0};
						bodyRows[freeSlot] <= 7'd1;
						pendDraw[freeSlot] <= 1'b1;
					end

					if (issueGo)
					begin
						spanStart <= 1'b1;
						if (issueErase)
							pendErase[issueSlot] <= 1'b0;
						else
							pendDraw[issueSlot] <= 1'b0;
					end

					if (missPress || fallMiss)
					begin
						phase <= phaseOverSweep;
						sweepOver <= 1'b1;
						pendDraw <= '0;
						pendErase <= '0;
					end
				end
				phaseIdle:
				begin
					if (lanePress != '0)
					begin
						phase <= phaseBackground;
						sweepOver <= 1'b0;
					end
				end
				default:
					phase <= phaseBackground;
			endcase
		end
	end

	// Span payload and queued rows
	always_ff @(posedge CLOCK_50)
	begin
		if (issueGo)
		begin
			span.startX <= laneStartX(tiles[issueSlot].lane);
			span.row <= issueErase ? eraseAt[issueSlot] : drawAt[issueSlot];
			span.color <= issueErase ? colorBackground : colorTile;
		end
		if (spawnGo)
			drawAt[freeSlot] <= '0;
		for (int s = 0; s < tileSlots; s++)
		begin
			if (tickGo && tiles[s].active)
			begin
				if (bodyRows[s] < yT'(tileHeight))
					drawAt[s] <= bodyRows[s];
				else
				begin
					drawAt[s] <= tiles[s].top + yT'(tileHeight);
					eraseAt[s] <= tiles[s].top;
				end
			end
		end
	end

endmodule

// File: src/screenSweep.sv
`timescale 1ns/1ps

module screenSweep
	import tilesScreenPkg::*;
(
	input logic CLOCK_50,
	input logic arstN,
	input logic sweepStart,
	input logic sweepOver,
	output pixelT sweepPixel,
	output logic sweepPlot,
	output logic sweepDone
);
	xT rasterX;
	yT rasterY;
	logic running;
	logic overMode;
	logic onBorder;
	logic lastPixel;

	// Green strip left of lane 0 and right of every lane
	always_comb
	begin
		onBorder = rasterX < xT'(borderWidth);
		for (int l = 0; l < laneCount; l++)
		begin
			if (rasterX >= laneStartX(2'(l)) + xT'(laneWidth) &&
				rasterX < laneStartX(2'(l)) + xT'(laneWidth + borderWidth))
				onBorder = 1'b1;
		end
	end

	assign lastPixel = rasterX == xT'(screenWidth - 1) && rasterY == yT'(screenHeight - 1);
	assign sweepPlot = running;
	assign sweepPixel.x = rasterX;
	assign sweepPixel.y = rasterY;
	assign sweepPixel.color = overMode ? colorGameOver :
		onBorder ? colorBorder :
		(rasterY == yT'(screenHeight - 1)) ? colorBoundary : colorBackground;

	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			rasterX <= '0;
			rasterY <= '0;
			running <= 1'b0;
			overMode <= 1'b0;
			sweepDone <= 1'b0;
		end
		else
		begin
			sweepDone <= 1'b0;
			if (sweepStart)
			begin
				rasterX <= '0;
				rasterY <= '0;
				running <= 1'b1;
				overMode <= sweepOver;
			end
			else if (running)
			begin
				// Raster order, x fastest
				if (rasterX == xT'(screenWidth - 1))
				begin
					rasterX <= '0;
					rasterY <= rasterY + 1'b1;
				end
				else
					rasterX <= rasterX + 1'b1;
				if (lastPixel)
				begin
					running <= 1'b0;
					sweepDone <= 1'b1;
				end
			end
		end
	end

endmodule

// File: src/pixelWriter.sv
`timescale 1ns/1ps

module pixelWriter
	import tilesScreenPkg::*;
(
	input logic CLOCK_50,
	input logic arstN,
	input logic spanStart,
	input spanT span,
	input pixelT sweepPixel,
	input logic sweepPlot,
	output logic spanBusy,
	output xT VGA_X,
	output yT VGA_Y,
	output colorT VGA_COLOR,
	output logic plot
);
	localparam int countBits = $clog2(laneWidth);

	spanT held;
	logic [countBits-1:0] pixelCount;
	pixelT spanPixel;
	pixelT outPixel;

	// Pixel 0 comes straight from the request, the rest from the held span
	always_comb
	begin
		if (spanStart)
		begin
			spanPixel.x = span.startX;
			spanPixel.y = span.row;
			spanPixel.color = span.color;
		end
		else
		begin
			spanPixel.x = held.startX + xT'(pixelCount);
			spanPixel.y = held.row;
			spanPixel.color = held.color;
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arstN)
	begin
		if (!arstN)
		begin
			spanBusy <= 1'b0;
			pixelCount <= '0;
			plot <= 1'b0;
		end
		else
		begin
			plot <= sweepPlot || spanStart || spanBusy;
			if (spanStart)
			begin
				spanBusy <= 1'b1;
				pixelCount <= countBits'(1);
			end
			else if (spanBusy)
			begin
				pixelCount <= pixelCount + 1'b1;
				if (pixelCount == countBits'(laneWidth - 1))
					spanBusy <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (spanStart)
			held <= span;
		outPixel <= sweepPlot ? sweepPixel : spanPixel;
	end

	assign VGA_X = outPixel.x;
	assign VGA_Y = outPixel.y;
	assign VGA_COLOR = outPixel.color;

endmodule

// File: src/scoreDisplay.sv
`timescale 1ns/1ps

module scoreDisplay
	import tilesGamePkg::*;
(
	input scoreT score,
	output logic [6:0] HEX0,
	output logic [6:0] HEX1
);
	logic [4:0] tens;
	logic [3:0] ones;

	// Active low segments, gfedcba
	function automatic logic [6:0] segments(input logic [4:0] digit);
		case (digit)
			5'd0: return 7'b1000000;
			5'd1: return 7'b1111001;
			5'd2: return 7'b0100100;
			5'd3: return 7'b0110000;
			5'd4: return 7'b0011001;
			5'd5: return 7'b0010010;
			5'd6: return 7'b0000010;
			5'd7: return 7'b1111000;
			5'd8: return 7'b0000000;
			5'd9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	always_comb
	begin
		tens = 5'(score / 8'd10);
		ones = 4'(score % 8'd10);
		// Tens above 9 fall to the blank pattern
		HEX1 = segments(tens);
		HEX0 = segments({1'b0, ones});
	end

endmodule

// File: src/pianoTiles.sv
`timescale 1ns/1ps

module pianoTiles
	import tilesScreenPkg::*, tilesGamePkg::*;
#(
	parameter int tickCycles = 416666,
	parameter int spawnCycles = 50000000,
	parameter logic [23:0] lfsrSeed = 24'h800001,
	parameter int tileSlots = 4
)
(
	input logic CLOCK_50,
	input logic arstN,
	input logic [3:0] KEY,
	output xT VGA_X,
	output yT VGA_Y,
	output colorT VGA_COLOR,
	output logic plot,
	output logic [6:0] HEX0,
	output logic [6:0] HEX1
);
	logic sweepStart;
	logic sweepOver;
	logic sweepDone;
	logic sweepPlot;
	pixelT sweepPixel;
	logic spanStart;
	logic spanBusy;
	spanT span;
	scoreT score;

	tileField #(
		.tickCycles(tickCycles),
		.spawnCycles(spawnCycles),
		.lfsrSeed(lfsrSeed),
		.tileSlots(tileSlots)
	) tileField_inst (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.KEY(KEY),
		.spanBusy(spanBusy),
		.sweepDone(sweepDone),
		.sweepStart(sweepStart),
		.sweepOver(sweepOver),
		.spanStart(spanStart),
		.span(span),
		.score(score)
	);

	screenSweep screenSweep_inst (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.sweepStart(sweepStart),
		.sweepOver(sweepOver),
		.sweepPixel(sweepPixel),
		.sweepPlot(sweepPlot),
		.sweepDone(sweepDone)
	);

	// Single frame buffer write port
	pixelWriter pixelWriter_inst (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.spanStart(spanStart),
		.span(span),
		.sweepPixel(sweepPixel),
		.sweepPlot(sweepPlot),
		.spanBusy(spanBusy),
		.VGA_X(VGA_X),
		.VGA_Y(VGA_Y),
		.VGA_COLOR(VGA_COLOR),
		.plot(plot)
	);

	scoreDisplay scoreDisplay_inst (
		.score(score),
		.HEX0(HEX0),
		.HEX1(HEX1)
	);

endmodule

// File: bench/pianoTiles_props.sv
`timescale 1ns/1ps

module pianoTilesProps
	import tilesScreenPkg::*;
(
	input logic CLOCK_50,
	input logic arstN,
	input logic plot,
	input xT VGA_X,
	input yT VGA_Y,
	input colorT VGA_COLOR,
	input logic [6:0] HEX0
);
	int violations = 0;

	// Green strips, left edge and right of every lane
	function automatic logic inBorder(input xT x);
		return int'(x) < borderWidth ||
			(int'(x) - borderWidth) % (laneWidth + borderWidth) >= laneWidth;
	endfunction

	plotOnScreen: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		plot |-> int'(VGA_X) < screenWidth && int'(VGA_Y) < screenHeight)
	else
	begin
		$error("Plot outside the frame at x %0d y %0d", VGA_X, VGA_Y);
		violations++;
	end

	// Active low patterns for 0 to 9
	hexDigitValid: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		HEX0 inside {7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
			7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000})
	else
	begin
		$error("HEX0 pattern %b is not a digit", HEX0);
		violations++;
	end

	tileOffBorder: assert property (@(posedge CLOCK_50) disable iff (!arstN)
		plot && VGA_COLOR == colorTile |-> !inBorder(VGA_X))
	else
	begin
		$error("Tile pixel drawn on a border strip at x %0d", VGA_X);
		violations++;
	end

endmodule

bind pianoTiles pianoTilesProps pianoTilesProps_inst (
	.CLOCK_50(CLOCK_50),
	.arstN(arstN),
	.plot(plot),
	.VGA_X(VGA_X),
	.VGA_Y(VGA_Y),
	.VGA_COLOR(VGA_COLOR),
	.HEX0(HEX0)
);

// File: bench/pianoTilesTb.sv
`timescale 1ns/1ps

module pianoTilesTb
	import tilesScreenPkg::*, tilesGamePkg::*;
();
	localparam int pitch = laneWidth + borderWidth;
	localparam int runTimeout = 6000;

	logic CLOCK_50;
	logic arstN;
	logic [3:0] KEY;
	xT VGA_X;
	yT VGA_Y;
	colorT VGA_COLOR;
	logic plot;
	logic [6:0] HEX0;
	logic [6:0] HEX1;

	string testName;
	int errorCount;
	int errorsAtStart;
	int testsPassed;
	int testsFailed;
	bit aborted;
	// Per lane model of what has been plotted
	int laneLow [laneCount];

	pianoTiles #(
		.tickCycles(400),
		.spawnCycles(3000)
	) pianoTiles_inst (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.KEY(KEY),
		.VGA_X(VGA_X),
		.VGA_Y(VGA_Y),
		.VGA_COLOR(VGA_COLOR),
		.plot(plot),
		.HEX0(HEX0),
		.HEX1(HEX1)
	);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #2 CLOCK_50 = ~CLOCK_50;
	end

	function automatic int allErrors();
		return errorCount + pianoTiles_inst.pianoTilesProps_inst.violations;
	endfunction

	function automatic bit onBorder(input int x);
		return x < borderWidth || (x - borderWidth) % pitch >= laneWidth;
	endfunction

	function automatic bit inLane(input int x);
		return x < screenWidth && !onBorder(x);
	endfunction

	function automatic int sweepColor(input int x, input int y, input bit over);
		if (over)
			return colorGameOver;
		if (onBorder(x))
			return colorBorder;
		if (y == screenHeight - 1)
			return colorBoundary;
		return colorBackground;
	endfunction

	// Segments gfedcba, low means lit
	function automatic int segDigit(input logic [6:0] seg);
		case (seg)
			7'b1000000: return 0;
			7'b1111001: return 1;
			7'b0100100: return 2;
			7'b0110000: return 3;
			7'b0011001: return 4;
			7'b0010010: return 5;
			7'b0000010: return 6;
			7'b1111000: return 7;
			7'b0000000: return 8;
			7'b0010000: return 9;
			default: return -1;
		endcase
	endfunction

	function automatic int scoreShown();
		if (segDigit(HEX1) < 0 || segDigit(HEX0) < 0)
			return -1;
		return segDigit(HEX1) * 10 + segDigit(HEX0);
	endfunction

	task automatic expectEqual(input string what, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("Fail %s %s expected %0d actual %0d", testName, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic beginTest(input string name);
		testName = name;
		errorsAtStart = allErrors();
	endtask

	task automatic endTest();
		if (aborted || allErrors() != errorsAtStart)
		begin
			$display("Test %s failed", testName);
			testsFailed++;
		end
		else
		begin
			$display("Test %s passed", testName);
			testsPassed++;
		end
	endtask

	// KEY[3] is lane 0
	task automatic pressKey(input int lane);
		@(posedge CLOCK_50);
		KEY[3 - lane] <= 1'b0;
		repeat (3) @(posedge CLOCK_50);
		KEY[3 - lane] <= 1'b1;
	endtask

	task automatic waitScore(input int expected);
		int cycles;
		cycles = 0;
		while (scoreShown() != expected && cycles < 300)
		begin
			@(negedge CLOCK_50);
			cycles++;
		end
		if (scoreShown() != expected)
			$display("Timed out in %s waiting for the score to show %0d", testName, expected);
	endtask

	// Ends at the negedge that shows the first pixel of the next run
	task automatic waitPlotStart();
		int cycles;
		cycles = 0;
		while (plot && cycles < runTimeout)
		begin
			@(negedge CLOCK_50);
			cycles++;
		end
		while (!plot && cycles < runTimeout)
		begin
			@(negedge CLOCK_50);
			cycles++;
		end
		if (!plot || cycles >= runTimeout)
		begin
			$display("Timed out in %s waiting for the next plotted pixel", testName);
			aborted = 1'b1;
		end
	endtask

	task automatic checkSweep(input bit over);
		int expectedColor;
		for (int i = 0; i < screenWidth * screenHeight; i++)
		begin
			expectedColor = sweepColor(i % screenWidth, i / screenWidth, over);
			if (!plot || int'(VGA_X) != i % screenWidth || int'(VGA_Y) != i / screenWidth ||
				int'(VGA_COLOR) != expectedColor)
			begin
				expectEqual("sweep plot", 1, int'(plot));
				expectEqual("sweep pixel index", i, int'(VGA_Y) * screenWidth + int'(VGA_X));
				expectEqual("sweep color", expectedColor, int'(VGA_COLOR));
				return;
			end
			@(negedge CLOCK_50);
		end
		expectEqual("plot after sweep", 0, int'(plot));
		// A background sweep starts a new game
		if (!over)
		begin
			for (int l = 0; l < laneCount; l++)
			begin
				laneLow[l] = -1;
			end
		end
	endtask

	task automatic checkSpan(output int row, output int lane, output int color);
		int startX;
		int length;
		startX = int'(VGA_X);
		row = int'(VGA_Y);
		color = int'(VGA_COLOR);
		lane = (startX - borderWidth) / pitch;
		length = 0;
		expectEqual("span start x", borderWidth + lane * pitch, startX);
		expectEqual("span color tile or background", 1,
			int'(color == colorTile || color == colorBackground));
		if (lane < 0 || lane >= laneCount)
			lane = 0;
		while (plot && length <= laneWidth)
		begin
			expectEqual("span pixel x", startX + length, int'(VGA_X));
			expectEqual("span pixel row", row, int'(VGA_Y));
			expectEqual("span pixel color", color, int'(VGA_COLOR));
			if (color == colorTile)
				expectEqual("tile pixel inside a lane", 1, int'(inLane(int'(VGA_X))));
			length++;
			@(negedge CLOCK_50);
		end
		expectEqual("span length", laneWidth, length);
		if (color == colorTile && row > laneLow[lane])
			laneLow[lane] = row;
		if (color == colorBackground)
		begin
			// Erased rows were drawn earlier in the same lane
			expectEqual("erased row above drawn rows", 1, int'(row <= laneLow[lane]));
		end
	endtask

	task automatic nextSpan(output int row, output int lane, output int color);
		waitPlotStart();
		if (aborted)
			return;
		if (VGA_X == '0 && VGA_Y == '0)
		begin
			$display("Unexpected full-frame sweep during %s", testName);
			aborted = 1'b1;
			return;
		end
		checkSpan(row, lane, color);
	endtask

	// Spans before the sweep are still checked
	task automatic awaitSweep(input bit over, input int maxRuns);
		int row;
		int lane;
		int color;
		for (int r = 0; r < maxRuns; r++)
		begin
			waitPlotStart();
			if (aborted)
				return;
			if (VGA_X == '0 && VGA_Y == '0)
			begin
				checkSweep(over);
				return;
			end
			checkSpan(row, lane, color);
		end
		$display("No full-frame sweep appeared during %s", testName);
		aborted = 1'b1;
	endtask

	task automatic runTests();
		int row;
		int lane;
		int color;
		int hitLane;
		int wrongLane;
		int pick;
		int tries;
		int plots;
		bit found;

		beginTest("reset sweep");
		awaitSweep(1'b0, 1);
		expectEqual("HEX1 digit", 0, segDigit(HEX1));
		expectEqual("HEX0 digit", 0, segDigit(HEX0));
		endTest();
		if (aborted)
			return;

		beginTest("tile spans");
		for (int n = 0; n < 12 && !aborted; n++)
			nextSpan(row, lane, color);
		endTest();
		if (aborted)
			return;

		beginTest("scoring press");
		found = 1'b0;
		for (int n = 0; n < 3000 && !aborted && !found; n++)
		begin
			nextSpan(row, lane, color);
			found = !aborted && color == colorTile && row >= judgeTop;
		end
		if (!found && !aborted)
		begin
			$display("No tile reached the judge zone during %s", testName);
			aborted = 1'b1;
		end
		hitLane = lane;
		if (!aborted)
		begin
			pressKey(hitLane);
			waitScore(1);
			expectEqual("score after hit", 1, scoreShown());
		end
		endTest();
		if (aborted)
			return;

		beginTest("wrong press");
		// Random lane whose tiles have not reached the judge zone
		wrongLane = (hitLane + 1) % laneCount;
		tries = 0;
		found = 1'b0;
		while (!found && tries < 16)
		begin
			pick = $urandom % laneCount;
			found = pick != hitLane && laneLow[pick] < judgeTop;
			tries++;
		end
		if (found)
			wrongLane = pick;
		fork
			pressKey(wrongLane);
		join_none
		awaitSweep(1'b1, 4);
		if (!aborted)
		begin
			expectEqual("score kept after game over", 1, scoreShown());
			plots = 0;
			for (int n = 0; n < 2000; n++)
			begin
				@(negedge CLOCK_50);
				plots += int'(plot);
			end
			expectEqual("plots while idle", 0, plots);
		end
		endTest();
		if (aborted)
			return;

		beginTest("restart");
		pick = $urandom % laneCount;
		fork
			pressKey(pick);
		join_none
		awaitSweep(1'b0, 1);
		expectEqual("HEX1 digit", 0, segDigit(HEX1));
		expectEqual("HEX0 digit", 0, segDigit(HEX0));
		endTest();
		if (aborted)
			return;

		// No presses, the first tile falls out
		beginTest("missed tile");
		awaitSweep(1'b1, 5000);
		expectEqual("score after miss", 0, scoreShown());
		endTest();
	endtask

	initial
	begin
		void'($urandom(73505));
		arstN = 1'b0;
		KEY = 4'hF;
		errorCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		aborted = 1'b0;
		testName = "reset";
		for (int l = 0; l < laneCount; l++)
		begin
			laneLow[l] = -1;
		end
		repeat (10) @(posedge CLOCK_50);
		arstN <= 1'b1;
		runTests();
		$display("Tests passed %0d failed %0d errors %0d", testsPassed, testsFailed, allErrors());
		if (testsPassed == 6 && testsFailed == 0 && allErrors() == 0 && !aborted)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: build.f
src/tilesScreenPkg.sv
src/tilesGamePkg.sv
src/tileField.sv
src/screenSweep.sv
src/pixelWriter.sv
src/scoreDisplay.sv
src/pianoTiles.sv
bench/pianoTiles_props.sv
bench/pianoTilesTb.sv

// File: Bender.yml
package:
  name: piano_tiles

sources:
  - files:
      - src/tilesScreenPkg.sv
      - src/tilesGamePkg.sv
      - src/tileField.sv
      - src/screenSweep.sv
      - src/pixelWriter.sv
      - src/scoreDisplay.sv
      - src/pianoTiles.sv
  - target: test
    files:
      - bench/pianoTiles_props.sv
      - bench/pianoTilesTb.sv
